//--- compile.f
verilog/qla_pkg.sv
verilog/reg_decode.sv
verilog/axis_regs.sv
verilog/board_regs.sv
verilog/read_result.sv
verilog/qla_reg_hub.sv
verification/qla_checker.sv
verification/tb_qla_reg_hub.sv

//--- Makefile
# register hub simulation with Verilator

.PHONY: sim clean

sim:
	verilator --binary --timing -f compile.f --top-module tb_qla_reg_hub -Mdir obj_dir
	./obj_dir/Vtb_qla_reg_hub | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_qla_reg_hub.sv
// --------------------
// hub testbench with NUM_AXES 4 and TRIP_COUNT 8
// both hosts drive on the rising edge and qla_checker compares
// each ack wait gives up after ACK_TMO cycles
// --------------------

`timescale 1ns/1ps
`default_nettype none

module tb_qla_reg_hub import qla_pkg::*; ();

    localparam int NUM_AXES   = 4;
    localparam int TRIP_COUNT = 8;
    localparam int ACK_TMO    = 50;       // cycles per ack wait

    logic                sysclk;
    logic                arst_n;
    logic                fw_cyc;
    logic                fw_stb;
    logic                fw_we;
    reg_addr_t           fw_adr;
    reg_data_t           fw_dat_w;
    reg_data_t           fw_dat_r;
    logic                fw_ack;
    logic                eth_cyc;
    logic                eth_stb;
    logic                eth_we;
    reg_addr_t           eth_adr;
    reg_data_t           eth_dat_w;
    reg_data_t           eth_dat_r;
    logic                eth_ack;
    cur_t [NUM_AXES-1:0] cur_fb;
    logic [3:0]          wenid;
    cur_t [NUM_AXES-1:0] dac_cmd;
    logic [NUM_AXES-1:0] amp_disable;
    logic [DOUT_W-1:0]   dout;
    logic [NUM_AXES-1:0] quiet_mask;

    int        err_cnt;                   // from the checker
    int        tmo_cnt;
    int        base_cnt;                  // failures before this test
    int        seed;
    cur_t      cmd_val [NUM_AXES];
    reg_data_t v;
    reg_data_t v2;
    reg_data_t rdata;
    reg_data_t rdata2;

    qla_reg_hub #(.NUM_AXES(NUM_AXES), .TRIP_COUNT(TRIP_COUNT)) dut (.*);

    qla_checker #(.NUM_AXES(NUM_AXES)) chk (.*);

    always #5 sysclk = ~sysclk;

    function automatic reg_addr_t make_addr(input logic [3:0] region, input int ch,
                                            input off_t off);
        return {region, 4'h0, chan_t'(ch), off};
    endfunction

    // --------------------
    // host ports
    // --------------------
    task automatic fw_access(input logic we, input reg_addr_t adr, input reg_data_t wdata,
                             output reg_data_t rd);
        int n;
        @(posedge sysclk);
        fw_cyc   <= 1'b1;
        fw_stb   <= 1'b1;
        fw_we    <= we;
        fw_adr   <= adr;
        fw_dat_w <= wdata;
        n = 0;
        @(posedge sysclk);
        while (!fw_ack && n < ACK_TMO) begin
            @(posedge sysclk);
            n++;
        end
        if (!fw_ack) begin
            $display("%0t timeout, no ack on the firewire port for address %h", $time, adr);
            tmo_cnt++;
        end
        rd = fw_dat_r;
        fw_cyc <= 1'b0;                   // drop on the ack edge
        fw_stb <= 1'b0;
    endtask

    task automatic eth_access(input logic we, input reg_addr_t adr, input reg_data_t wdata,
                              output reg_data_t rd);
        int n;
        @(posedge sysclk);
        eth_cyc   <= 1'b1;
        eth_stb   <= 1'b1;
        eth_we    <= we;
        eth_adr   <= adr;
        eth_dat_w <= wdata;
        n = 0;
        @(posedge sysclk);
        while (!eth_ack && n < ACK_TMO) begin
            @(posedge sysclk);
            n++;
        end
        if (!eth_ack) begin
            $display("%0t timeout, no ack on the ethernet port for address %h", $time, adr);
            tmo_cnt++;
        end
        rd = eth_dat_r;
        eth_cyc <= 1'b0;
        eth_stb <= 1'b0;
    endtask

    task automatic wait_trip(input int idx);
        int n;
        n = 0;
        while (!amp_disable[idx] && n < 4 * TRIP_COUNT) begin
            @(posedge sysclk);
            n++;
        end
        if (!amp_disable[idx]) begin
            $display("%0t timeout, amp_disable[%0d] never tripped", $time, idx);
            tmo_cnt++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        int fails;
        @(negedge sysclk);                // checker is done with the last edge
        fails    = err_cnt + tmo_cnt - base_cnt;
        base_cnt = err_cnt + tmo_cnt;
        $display("test %0d %s: %0d failures", num, name, fails);
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        seed       = 23021;
        sysclk     = 1'b0;
        arst_n     = 1'b0;
        fw_cyc     = 1'b0;
        fw_stb     = 1'b0;
        fw_we      = 1'b0;
        fw_adr     = '0;
        fw_dat_w   = '0;
        eth_cyc    = 1'b0;
        eth_stb    = 1'b0;
        eth_we     = 1'b0;
        eth_adr    = '0;
        eth_dat_w  = '0;
        cur_fb     = '0;
        wenid      = 4'b1010;             // board id 5
        quiet_mask = '0;
        tmo_cnt    = 0;
        base_cnt   = 0;
        repeat (10) @(posedge sysclk);
        arst_n <= 1'b1;

        for (int a = 1; a <= NUM_AXES; a++) begin
            v            = $random(seed);
            cmd_val[a-1] = v[15:0];
            fw_access(1'b1, make_addr(ADDR_MAIN, a, OFF_DAC_CTRL), v, rdata);
            fw_access(1'b0, make_addr(ADDR_MAIN, a, OFF_DAC_CTRL), '0, rdata);
        end
        finish_test(1, "dac command write and readback");

        @(posedge sysclk);
        for (int a = 0; a < NUM_AXES; a++)
            cur_fb[a] <= cmd_val[a] >> 1; // half the command never trips
        for (int a = 1; a <= NUM_AXES; a++)
            fw_access(1'b0, make_addr(ADDR_MAIN, a, OFF_ADC_DATA), '0, rdata);
        fw_access(1'b0, make_addr(ADDR_MAIN, 0, OFF_STATUS), '0, rdata);
        finish_test(2, "feedback readback and board id");

        fw_access(1'b0, make_addr(4'h5, 1, OFF_DAC_CTRL), '0, rdata);
        fw_access(1'b0, make_addr(ADDR_MAIN, NUM_AXES + 1, OFF_DAC_CTRL), '0, rdata);
        eth_access(1'b1, make_addr(4'h5, 1, OFF_DAC_CTRL), 32'h0000_1234, rdata);
        eth_access(1'b1, make_addr(4'hF, 0, OFF_DOUT_CTRL), 32'h0000_000F, rdata);
        fw_access(1'b1, make_addr(ADDR_MAIN, NUM_AXES + 1, OFF_DAC_CTRL), 32'h5555, rdata);
        finish_test(3, "unmapped region and absent channel");

        for (int a = 1; a <= NUM_AXES; a++) begin
            @(posedge sysclk);
            cur_fb[a-1] <= 16'd250;       // over twice the command below
            fw_access(1'b1, make_addr(ADDR_MAIN, a, OFF_DAC_CTRL), 32'd100, rdata);
            wait_trip(a - 1);
            fw_access(1'b0, make_addr(ADDR_MAIN, 0, OFF_STATUS), '0, rdata);
            @(posedge sysclk);
            cur_fb[a-1] <= 16'd150;
            eth_access(1'b1, make_addr(ADDR_MAIN, a, OFF_DAC_CTRL), 32'd100, rdata);
            quiet_mask[a-1] <= 1'b1;      // latch cleared and must stay low
            repeat (4 * TRIP_COUNT) @(posedge sysclk);
            quiet_mask[a-1] <= 1'b0;
        end
        finish_test(4, "safety trip and clear");

        v  = $random(seed);
        v2 = $random(seed);
        fork
            fw_access(1'b1, make_addr(ADDR_MAIN, 1, OFF_DAC_CTRL), v, rdata);
            eth_access(1'b1, make_addr(ADDR_MAIN, 2, OFF_DAC_CTRL), v2, rdata2);
        join
        fork
            fw_access(1'b0, make_addr(ADDR_MAIN, 1, OFF_DAC_CTRL), '0, rdata);
            eth_access(1'b0, make_addr(ADDR_MAIN, 2, OFF_DAC_CTRL), '0, rdata2);
        join
        finish_test(5, "overlapping access on both ports");

        v = $random(seed);
        eth_access(1'b1, make_addr(ADDR_MAIN, 0, OFF_DOUT_CTRL), v, rdata);
        eth_access(1'b0, make_addr(ADDR_MAIN, 0, OFF_DOUT_CTRL), '0, rdata);
        finish_test(6, "digital outputs over ethernet");

        $display("tests 6, checker errors %0d, timeouts %0d", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/qla_checker.sv
// --------------------
// watches the hub ports, keeps a model of dac_cmd and dout
// amp_disable latches are not modelled, status reads use the port
// quiet_mask bits from the testbench mark axes that must not trip
// --------------------

`timescale 1ns/1ps
`default_nettype none

module qla_checker import qla_pkg::*; #(
    parameter int NUM_AXES = 4
) (
    input  wire logic                sysclk,
    input  wire logic                arst_n,

    input  wire logic                fw_we,
    input  wire reg_addr_t           fw_adr,
    input  wire reg_data_t           fw_dat_w,
    input  wire reg_data_t           fw_dat_r,
    input  wire logic                fw_ack,

    input  wire logic                eth_we,
    input  wire reg_addr_t           eth_adr,
    input  wire reg_data_t           eth_dat_w,
    input  wire reg_data_t           eth_dat_r,
    input  wire logic                eth_ack,

    input  wire cur_t [NUM_AXES-1:0] cur_fb,
    input  wire logic [3:0]          wenid,
    input  wire cur_t [NUM_AXES-1:0] dac_cmd,
    input  wire logic [NUM_AXES-1:0] amp_disable,
    input  wire logic [DOUT_W-1:0]   dout,
    input  wire logic [NUM_AXES-1:0] quiet_mask,   // these axes must stay enabled

    output int                       err_cnt
);

    localparam chan_t MAX_CHAN = chan_t'(NUM_AXES);

    cur_t              model_cmd [16];    // by channel, entry 0 unused
    logic [DOUT_W-1:0] model_dout;

    task automatic mismatch(input string sig, input reg_data_t exp, input reg_data_t got);
        err_cnt++;
        $display("ERR %0t %s exp %h got %h", $time, sig, exp, got);
    endtask

    // --------------------
    // reference read data
    // --------------------
    function automatic reg_data_t expect_rdata(input reg_addr_t adr);
        chan_t     ch;
        off_t      off;
        reg_data_t ret;
        ch  = adr[7:4];
        off = adr[3:0];
        ret = '0;                                   // unmapped, absent or unused
        if (adr[15:12] == ADDR_MAIN && ch <= MAX_CHAN) begin
            if (ch == 4'd0) begin
                if (off == OFF_STATUS) begin
                    ret[STATUS_ID_LSB +: 4] = ~wenid;   // id from the switch
                    ret[NUM_AXES-1:0]       = amp_disable;
                end else if (off == OFF_DOUT_CTRL) begin
                    ret = reg_data_t'(model_dout);
                end
            end else if (off == OFF_ADC_DATA) begin
                for (int i = 0; i < NUM_AXES; i++) begin
                    if (ch == chan_t'(i + 1))
                        ret = reg_data_t'(cur_fb[i]);
                end
            end else if (off == OFF_DAC_CTRL) begin
                ret = reg_data_t'(model_cmd[ch]);
            end
        end
        return ret;
    endfunction

    // output ports against the model, after every write
    task automatic compare_outputs();
        for (int i = 1; i <= NUM_AXES; i++) begin
            if (dac_cmd[i-1] !== model_cmd[i])
                mismatch($sformatf("dac_cmd[%0d]", i - 1),
                         reg_data_t'(model_cmd[i]), reg_data_t'(dac_cmd[i-1]));
        end
        if (dout !== model_dout)
            mismatch("dout", reg_data_t'(model_dout), reg_data_t'(dout));
    endtask

    task automatic check_access(input string sig, input logic we, input reg_addr_t adr,
                                input reg_data_t wdata, input reg_data_t rdata);
        chan_t     ch;
        reg_data_t exp;
        ch = adr[7:4];
        if (!we) begin
            exp = expect_rdata(adr);
            if (rdata !== exp)
                mismatch(sig, exp, rdata);
        end else begin
            if (adr[15:12] == ADDR_MAIN && adr[3:0] == OFF_DAC_CTRL
                    && ch != 4'd0 && ch <= MAX_CHAN)
                model_cmd[ch] = wdata[15:0];
            if (adr[15:12] == ADDR_MAIN && adr[3:0] == OFF_DOUT_CTRL && ch == 4'd0)
                model_dout = wdata[DOUT_W-1:0];
            compare_outputs();                      // write took effect one edge ago
        end
    endtask

    // --------------------
    // monitor
    // --------------------
    always @(posedge sysclk) begin
        if (!arst_n) begin
            err_cnt    = 0;
            model_dout = '0;
            for (int i = 0; i < 16; i++)
                model_cmd[i] = '0;
        end else begin
            if (fw_ack && eth_ack) begin
                err_cnt++;
                $display("%0t both ports acked in the same cycle", $time);
            end
            if (fw_ack)
                check_access("fw_dat_r", fw_we, fw_adr, fw_dat_w, fw_dat_r);
            if (eth_ack)
                check_access("eth_dat_r", eth_we, eth_adr, eth_dat_w, eth_dat_r);
            for (int i = 0; i < NUM_AXES; i++) begin
                if (quiet_mask[i] && amp_disable[i])
                    mismatch($sformatf("amp_disable[%0d]", i), 32'd0, 32'd1);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/qla_reg_hub.sv
// --------------------
// register hub top, four-axis motor controller board
// two Wishbone classic slave ports, firewire and ethernet
// ADC currents in and DAC commands out are parallel words
// NUM_AXES 1..8, axis n answers on channel n
// --------------------

`timescale 1ns/1ps
`default_nettype none

module qla_reg_hub import qla_pkg::*; #(
    parameter int NUM_AXES   = 4,      // axis channels
    parameter int TRIP_COUNT = 8       // over-limit cycles before trip
) (
    input  wire logic                sysclk,
    input  wire logic                arst_n,

    // firewire host port
    input  wire logic                fw_cyc,
    input  wire logic                fw_stb,
    input  wire logic                fw_we,
    input  wire reg_addr_t           fw_adr,
    input  wire reg_data_t           fw_dat_w,
    output reg_data_t                fw_dat_r,
    output logic                     fw_ack,

    // ethernet host port
    input  wire logic                eth_cyc,
    input  wire logic                eth_stb,
    input  wire logic                eth_we,
    input  wire reg_addr_t           eth_adr,
    input  wire reg_data_t           eth_dat_w,
    output reg_data_t                eth_dat_r,
    output logic                     eth_ack,

    // board I/O
    input  wire cur_t [NUM_AXES-1:0] cur_fb,       // current feedback per axis
    input  wire logic [3:0]          wenid,        // rotary switch, active low
    output cur_t [NUM_AXES-1:0]      dac_cmd,
    output logic [NUM_AXES-1:0]      amp_disable,
    output logic [DOUT_W-1:0]        dout
);

    // --------------------
    // access bus
    // --------------------
    logic                     acc_valid;
    logic                     acc_we;
    logic                     acc_main;
    logic                     acc_eth;
    chan_t                    acc_chan;
    off_t                     acc_off;
    reg_data_t                acc_wdata;
    logic                     acc_done;

    logic                     wr_any;        // valid mapped write
    logic                     board_wr;
    logic [NUM_AXES-1:0]      axis_wr;
    reg_data_t                board_word;
    reg_data_t [NUM_AXES-1:0] axis_words;

    reg_decode #(.NUM_AXES(NUM_AXES)) u_decode (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .fw_cyc    (fw_cyc),
        .fw_stb    (fw_stb),
        .fw_we     (fw_we),
        .fw_adr    (fw_adr),
        .fw_dat_w  (fw_dat_w),
        .eth_cyc   (eth_cyc),
        .eth_stb   (eth_stb),
        .eth_we    (eth_we),
        .eth_adr   (eth_adr),
        .eth_dat_w (eth_dat_w),
        .acc_done  (acc_done),
        .acc_valid (acc_valid),
        .acc_we    (acc_we),
        .acc_main  (acc_main),
        .acc_eth   (acc_eth),
        .acc_chan  (acc_chan),
        .acc_off   (acc_off),
        .acc_wdata (acc_wdata)
    );

    // per-channel write strobes
    assign wr_any   = acc_valid & acc_we & acc_main;
    assign board_wr = wr_any & (acc_chan == '0);

    // --------------------
    // execute, board + axes
    // --------------------
    board_regs #(.NUM_AXES(NUM_AXES)) u_board (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .wr_en       (board_wr),
        .acc_off     (acc_off),
        .acc_wdata   (acc_wdata),
        .wenid       (wenid),
        .amp_disable (amp_disable),
        .dout        (dout),
        .rd_word     (board_word)
    );

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        assign axis_wr[i] = wr_any & (acc_chan == chan_t'(i + 1));   // axis i on chan i+1

        axis_regs #(.TRIP_COUNT(TRIP_COUNT)) u_axis (
            .sysclk      (sysclk),
            .arst_n      (arst_n),
            .wr_en       (axis_wr[i]),
            .acc_off     (acc_off),
            .acc_wdata   (acc_wdata),
            .cur_fb      (cur_fb[i]),
            .dac_cmd     (dac_cmd[i]),
            .amp_disable (amp_disable[i]),
            .rd_word     (axis_words[i])
        );
    end

    // --------------------
    // result, read mux and ack
    // --------------------
    read_result #(.NUM_AXES(NUM_AXES)) u_result (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .acc_valid  (acc_valid),
        .acc_we     (acc_we),
        .acc_main   (acc_main),
        .acc_eth    (acc_eth),
        .acc_chan   (acc_chan),
        .board_word (board_word),
        .axis_words (axis_words),
        .fw_dat_r   (fw_dat_r),
        .fw_ack     (fw_ack),
        .eth_dat_r  (eth_dat_r),
        .eth_ack    (eth_ack),
        .acc_done   (acc_done)
    );

endmodule

`default_nettype wire

//--- verilog/read_result.sv
// --------------------
// read select and Wishbone ack
// writes and unmapped accesses return 0 but are still acked
// ack goes to the winning port only, one cycle wide
// --------------------

`timescale 1ns/1ps
`default_nettype none

module read_result import qla_pkg::*; #(
    parameter int NUM_AXES = 4
) (
    input  wire logic                     sysclk,
    input  wire logic                     arst_n,

    input  wire logic                     acc_valid,
    input  wire logic                     acc_we,
    input  wire logic                     acc_main,
    input  wire logic                     acc_eth,
    input  wire chan_t                    acc_chan,
    input  wire reg_data_t                board_word,   // channel 0
    input  wire reg_data_t [NUM_AXES-1:0] axis_words,   // channels 1..NUM_AXES

    output reg_data_t                     fw_dat_r,
    output logic                          fw_ack,
    output reg_data_t                     eth_dat_r,
    output logic                          eth_ack,
    output logic                          acc_done      // back to decode
);

    reg_data_t rd_sel;

    // channel select
    always_comb begin
        rd_sel = '0;
        if (!acc_we && acc_main) begin
            if (acc_chan == '0)
                rd_sel = board_word;
            for (int i = 0; i < NUM_AXES; i++) begin
                if (acc_chan == chan_t'(i + 1))
                    rd_sel = axis_words[i];
            end
        end
    end

    // --------------------
    // ack, one cycle after acc_valid
    // --------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            fw_ack   <= 1'b0;
            eth_ack  <= 1'b0;
            acc_done <= 1'b0;
        end else begin
            fw_ack   <= acc_valid & ~acc_eth;
            eth_ack  <= acc_valid &  acc_eth;
            acc_done <= acc_valid;
        end
    end

    // read data per port, only meaningful while its ack is high
    always_ff @(posedge sysclk) begin
        if (acc_valid) begin
            if (acc_eth)
                eth_dat_r <= rd_sel;
            else
                fw_dat_r  <= rd_sel;
        end
    end

endmodule

`default_nettype wire

//--- verilog/board_regs.sv
// --------------------
// channel 0, board registers
// status word: ~wenid at bit 24, amp disables from bit 0
// wenid is the active-low rotary switch
// --------------------

`timescale 1ns/1ps
`default_nettype none

module board_regs import qla_pkg::*; #(
    parameter int NUM_AXES = 4
) (
    input  wire logic                sysclk,
    input  wire logic                arst_n,

    input  wire logic                wr_en,        // write to channel 0
    input  wire off_t                acc_off,
    input  wire reg_data_t           acc_wdata,
    input  wire logic [3:0]          wenid,        // board id, active low
    input  wire logic [NUM_AXES-1:0] amp_disable,  // from the axis channels

    output logic [DOUT_W-1:0]        dout,
    output reg_data_t                rd_word
);

    reg_data_t status_word;

    // digital output register
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            dout <= '0;
        else if (wr_en && (acc_off == OFF_DOUT_CTRL))
            dout <= acc_wdata[DOUT_W-1:0];
    end

    // --------------------
    // status and readback
    // --------------------
    always_comb begin
        status_word                          = '0;
        status_word[STATUS_ID_LSB +: 4]      = ~wenid;       // switch is inverted
        status_word[NUM_AXES-1:0]            = amp_disable;  // axis 1 at bit 0
    end

    always_comb begin
        case (acc_off)
            OFF_STATUS:    rd_word = status_word;
            OFF_DOUT_CTRL: rd_word = reg_data_t'(dout);
            default:       rd_word = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/axis_regs.sv
// --------------------
// one axis channel: DAC current command, feedback readback, safety trip
// trip when feedback > 2 * command for TRIP_COUNT cycles in a row
// the trip latches, only a command write clears it
// --------------------

`timescale 1ns/1ps
`default_nettype none

module axis_regs import qla_pkg::*; #(
    parameter int TRIP_COUNT = 8        // consecutive over-limit cycles
) (
    input  wire logic      sysclk,
    input  wire logic      arst_n,

    input  wire logic      wr_en,       // write to this channel
    input  wire off_t      acc_off,
    input  wire reg_data_t acc_wdata,
    input  wire cur_t      cur_fb,      // parallel ADC current

    output cur_t           dac_cmd,     // parallel DAC command
    output logic           amp_disable, // latched safety trip
    output reg_data_t      rd_word      // read data for acc_off
);

    localparam int CNT_W = $clog2(TRIP_COUNT + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(TRIP_COUNT);

    logic             cmd_wr;          // write hits the command register
    logic             over_lim;
    logic [16:0]      fb_ext;          // one extra bit so 2x cmd cannot wrap
    logic [16:0]      cmd_x2;
    logic [CNT_W-1:0] trip_cnt;

    assign cmd_wr = wr_en & (acc_off == OFF_DAC_CTRL);

    // --------------------
    // safety compare
    // --------------------
    assign fb_ext   = {1'b0, cur_fb};
    assign cmd_x2   = {dac_cmd, 1'b0};
    assign over_lim = fb_ext > cmd_x2;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            dac_cmd     <= '0;
            trip_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (cmd_wr) begin
            dac_cmd     <= acc_wdata[15:0];     // low half is the command
            trip_cnt    <= '0;
            amp_disable <= 1'b0;                // new command rearms the check
        end else if (over_lim) begin
            if (trip_cnt != CNT_MAX)
                trip_cnt <= trip_cnt + 1'b1;
            else
                amp_disable <= 1'b1;            // held until next cmd write
        end else begin
            trip_cnt <= '0;                     // must be consecutive
        end
    end

    // --------------------
    // readback
    // --------------------
    always_comb begin
        case (acc_off)
            OFF_ADC_DATA: rd_word = reg_data_t'(cur_fb);
            OFF_DAC_CTRL: rd_word = reg_data_t'(dac_cmd);
            default:      rd_word = '0;         // unused offsets
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/reg_decode.sv
// --------------------
// two-port Wishbone classic arbiter and address decode
// ethernet wins when both ports request in the same cycle
// one access in flight and held busy until acc_done
// a losing port just waits with no timeout
// --------------------

`timescale 1ns/1ps
`default_nettype none

module reg_decode import qla_pkg::*; #(
    parameter int NUM_AXES = 4          // axis channels 1..NUM_AXES
) (
    input  wire logic      sysclk,
    input  wire logic      arst_n,

    // firewire host port request side
    input  wire logic      fw_cyc,
    input  wire logic      fw_stb,
    input  wire logic      fw_we,
    input  wire reg_addr_t fw_adr,
    input  wire reg_data_t fw_dat_w,

    // ethernet host port request side
    input  wire logic      eth_cyc,
    input  wire logic      eth_stb,
    input  wire logic      eth_we,
    input  wire reg_addr_t eth_adr,
    input  wire reg_data_t eth_dat_w,

    input  wire logic      acc_done,      // result stage has acked

    // accepted access
    output logic           acc_valid,     // one-cycle strobe
    output logic           acc_we,
    output logic           acc_main,      // mapped main space with channel present
    output logic           acc_eth,       // high when ethernet won
    output chan_t          acc_chan,
    output off_t           acc_off,
    output reg_data_t      acc_wdata
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } dec_state_t;

    localparam chan_t MAX_CHAN = chan_t'(NUM_AXES);   // highest axis channel

    dec_state_t state;

    logic      fw_req;
    logic      eth_req;
    logic      grant;       // accept this cycle
    logic      sel_we;
    reg_addr_t sel_adr;
    reg_data_t sel_wdata;

    // --------------------
    // request select
    // --------------------
    assign fw_req  = fw_cyc & fw_stb;
    assign eth_req = eth_cyc & eth_stb;
    assign grant   = (state == ST_IDLE) & (fw_req | eth_req);

    // eth has priority over firewire
    assign sel_we    = eth_req ? eth_we    : fw_we;
    assign sel_adr   = eth_req ? eth_adr   : fw_adr;
    assign sel_wdata = eth_req ? eth_dat_w : fw_dat_w;

    // --------------------
    // idle / busy control
    // --------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= 1'b0;                  // strobe defaults low
            case (state)
                ST_IDLE: begin
                    if (grant) begin
                        state     <= ST_BUSY;
                        acc_valid <= 1'b1;
                    end
                end
                ST_BUSY: begin
                    if (acc_done)
                        state <= ST_IDLE;       // nothing accepted on this edge
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // access fields load only when a port wins
    always_ff @(posedge sysclk) begin
        if (grant) begin
            acc_eth   <= eth_req;
            acc_we    <= sel_we;
            acc_wdata <= sel_wdata;
            acc_chan  <= sel_adr[7:4];
            acc_off   <= sel_adr[3:0];
            // channels past the last axis behave like an unmapped region
            acc_main  <= (sel_adr[15:12] == ADDR_MAIN) && (sel_adr[7:4] <= MAX_CHAN);
        end
    end

endmodule

`default_nettype wire

//--- verilog/qla_pkg.sv
// --------------------
// shared widths, types and address map for the register hub
// address layout: [15:12] region, [7:4] channel, [3:0] offset
// bits 11..8 are ignored by the decode
// channel 0 is the board, channels 1..NUM_AXES are the axes
// --------------------

`default_nettype none

package qla_pkg;

    // --------------------
    // bus and payload types
    // --------------------
    typedef logic [15:0] reg_addr_t;   // host register address
    typedef logic [31:0] reg_data_t;   // host register data
    typedef logic [15:0] cur_t;        // motor current, feedback or command
    typedef logic [3:0]  chan_t;       // channel, address bits 7..4
    typedef logic [3:0]  off_t;        // offset in channel, bits 3..0

    // --------------------
    // address map
    // --------------------
    localparam logic [3:0] ADDR_MAIN = 4'd0;   // board + axis space, others unmapped

    // axis channel offsets
    localparam off_t OFF_ADC_DATA  = 4'd0;     // current feedback, read only
    localparam off_t OFF_DAC_CTRL  = 4'd1;     // current command, read/write

    // board channel offsets
    localparam off_t OFF_STATUS    = 4'd0;     // id + amp disable bits
    localparam off_t OFF_DOUT_CTRL = 4'd1;     // digital outputs

    // --------------------
    // status word layout
    // --------------------
    localparam int STATUS_ID_LSB = 24;         // 4-bit board id sits here
    localparam int DOUT_W        = 4;          // digital output count

endpackage

`default_nettype wire
